// File: flist.f
+incdir+hw
hw/pet_bus_pkg.sv
hw/pet_mem_pkg.sv
hw/bus_sequencer.sv
hw/pi_sync.sv
hw/pi_ctl_reg.sv
hw/address_decoder.sv
hw/pet_bus_top.sv
tb/tb_pet_bus.sv

// File: hw/address_decoder.sv
// --------------------------------------------------------------------------
// PET memory map decode: RAM, video RAM, ROM and I/O regions
// Active-low PIA1, PIA2, VIA, CRTC selects and I/O output enable
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "pet_config.svh"

module address_decoder (
    input  wire logic [15:0]        bus_addr_i,
    input  wire logic               cpu_be_i,       // CPU owns the bus and is ready
    output pet_mem_pkg::mem_region_e region_o,
    output logic                    pia1_cs_b_o,
    output logic                    pia2_cs_b_o,
    output logic                    via_cs_b_o,
    output logic                    crtc_cs_b_o,
    output logic                    io_oe_b_o
);
    logic io_page;      // $E8xx
    logic pia1_sel;
    logic pia2_sel;
    logic via_sel;
    logic crtc_sel;

    always_comb begin
        if (!bus_addr_i[15]) begin
            region_o = pet_mem_pkg::REGION_RAM;          // Lower 32K
        end else if (bus_addr_i[15:12] == 4'h8) begin
            region_o = pet_mem_pkg::REGION_VRAM;         // Screen memory
        end else if (bus_addr_i[15:11] == 5'b11101) begin
            region_o = pet_mem_pkg::REGION_IO;           // $E800-$EFFF
        end else begin
            region_o = pet_mem_pkg::REGION_ROM;          // BASIC, editor, kernal
        end
    end

    assign io_page = (bus_addr_i[15:8] == `PET_IO_PAGE);

    // PET style sparse decode, one address line per chip
    // PIA1 $E810, PIA2 $E820, VIA $E840, CRTC $E880
    assign pia1_sel = io_page && bus_addr_i[4];
    assign pia2_sel = io_page && bus_addr_i[5];
    assign via_sel  = io_page && bus_addr_i[6];
    assign crtc_sel = io_page && bus_addr_i[7];

    // Nothing selects unless the CPU is actually on the bus
    assign pia1_cs_b_o = !(pia1_sel && cpu_be_i);
    assign pia2_cs_b_o = !(pia2_sel && cpu_be_i);
    assign via_cs_b_o  = !(via_sel  && cpu_be_i);
    assign crtc_cs_b_o = !(crtc_sel && cpu_be_i);

    // Steers the I/O data path instead of RAM
    assign io_oe_b_o   = !(io_page && cpu_be_i);

endmodule

`default_nettype wire

// File: hw/bus_sequencer.sv
// --------------------------------------------------------------------------
// Frame sequencer: 4-bit phase counter on the 16 MHz clock
// Registered slot selects, video strobes, clk8 and phi2
// CPU read/write qualifiers during phi2
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "pet_config.svh"

module bus_sequencer (
    input  wire logic                   clk16_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   bus_rw_b_i,         // 0 = CPU writing
    output pet_bus_pkg::bus_slot_e      slot_o,
    output logic                        clk8_o,
    output logic                        phi2_o,
    output logic                        pi_select_o,
    output logic                        pi_strobe_o,
    output logic                        video_select_o,
    output logic                        video_ram_strobe_o,
    output logic                        video_rom_strobe_o,
    output logic                        cpu_select_o,
    output logic                        cpu_read_o,
    output logic                        cpu_write_o
);
    logic [3:0] phase_q;                // Position within the frame

    // Inclusive phase window test
    function automatic logic in_window(input logic [3:0] p, input int first, input int last);
        return (int'(p) >= first) && (int'(p) <= last);
    endfunction

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
        end else if (phase_q == 4'(`PET_FRAME_LEN - 1)) begin
            phase_q <= '0;              // Start of next CPU cycle
        end else begin
            phase_q <= phase_q + 4'd1;
        end
    end

    // All decodes lag the counter by one cycle
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_o             <= pet_bus_pkg::SLOT_PI;
            clk8_o             <= 1'b0;
            phi2_o             <= 1'b0;
            pi_select_o        <= 1'b0;
            pi_strobe_o        <= 1'b0;
            video_select_o     <= 1'b0;
            video_ram_strobe_o <= 1'b0;
            video_rom_strobe_o <= 1'b0;
            cpu_select_o       <= 1'b0;
        end else begin
            if (in_window(phase_q, `PET_PI_FIRST, `PET_PI_LAST))
                slot_o <= pet_bus_pkg::SLOT_PI;
            else if (in_window(phase_q, `PET_VID_FIRST, `PET_VID_LAST))
                slot_o <= pet_bus_pkg::SLOT_VIDEO;
            else
                slot_o <= pet_bus_pkg::SLOT_CPU;
            clk8_o             <= phase_q[0];   // Half rate of clk16
            phi2_o             <= in_window(phase_q, `PET_PHI2_FIRST, `PET_FRAME_LEN - 1);
            pi_select_o        <= in_window(phase_q, `PET_PI_FIRST, `PET_PI_LAST);
            pi_strobe_o        <= (int'(phase_q) == `PET_PI_STROBE);
            video_select_o     <= in_window(phase_q, `PET_VID_FIRST, `PET_VID_LAST);
            video_ram_strobe_o <= (int'(phase_q) == `PET_VID_RAM_STROBE);
            video_rom_strobe_o <= (int'(phase_q) == `PET_VID_ROM_STROBE);
            cpu_select_o       <= in_window(phase_q, `PET_CPU_FIRST, `PET_FRAME_LEN - 1);
        end
    end

    // rw is only meaningful while phi2 is high
    assign cpu_read_o  =  bus_rw_b_i && phi2_o;
    assign cpu_write_o = !bus_rw_b_i && phi2_o;

endmodule

`default_nettype wire

// File: hw/pet_bus_pkg.sv
// --------------------------------------------------------------------------
// Bus timing types: slot owners within a frame
// and the host access handshake states
// --------------------------------------------------------------------------
`default_nettype none

package pet_bus_pkg;

    // Owner of the shared bus for the current part of the frame
    typedef enum logic [1:0] {
        SLOT_PI    = 2'd0,  // Host (Pi) read/write window
        SLOT_VIDEO = 2'd1,  // Video RAM / ROM fetch
        SLOT_CPU   = 2'd2   // 6502 owns the bus
    } bus_slot_e;

    // Host access sequencing
    //   IDLE   : waiting for pending inside the host slot
    //   ACCESS : strobe issued last cycle, done just raised
    //   DONE   : done held until the host drops pending
    typedef enum logic [1:0] {
        PI_IDLE   = 2'd0,
        PI_ACCESS = 2'd1,
        PI_DONE   = 2'd2
    } pi_state_e;

endpackage

`default_nettype wire

// File: hw/pet_bus_top.sv
// --------------------------------------------------------------------------
// PET bus glue top level: sequencer, host sync, control register, decoder
// RAM strobes, CPU bus enable and upper RAM address steering
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pet_bus_top (
    input  wire logic        clk16_i,        // 16 MHz master clock
    input  wire logic        rst_n_i,
    input  wire logic        bus_rw_b_i,     // CPU rw, 0 = write
    input  wire logic        pi_pending_i,
    input  wire logic        pi_rw_b_i,
    input  wire logic [15:0] bus_addr_i,
    input  wire logic [15:0] pi_addr_i,
    input  wire logic [7:0]  pi_data_i,
    output logic             clk8_o,
    output logic             phi2_o,         // 1 MHz CPU clock
    output logic             pi_done_o,
    output logic             cpu_res_b_o,
    output logic             cpu_rdy_o,
    output logic             cpu_be_o,
    output logic             ram_ce_b_o,
    output logic             ram_oe_b_o,
    output logic             ram_we_b_o,
    output logic             pia1_cs_b_o,
    output logic             pia2_cs_b_o,
    output logic             via_cs_b_o,
    output logic             crtc_cs_b_o,
    output logic             io_oe_b_o,
    output logic             video_select_o,
    output logic             video_ram_strobe_o,
    output logic             video_rom_strobe_o,
    output logic [1:0]       ram_addr_hi_o   // RAM A11..A10
);
    pet_bus_pkg::bus_slot_e   slot;
    pet_mem_pkg::mem_region_e region;
    logic pi_select, pi_strobe;
    logic pi_read, pi_write;
    logic cpu_select, cpu_read, cpu_write;
    logic ram_ce, ram_oe, ram_we;

    bus_sequencer u_seq (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i), .bus_rw_b_i(bus_rw_b_i),
        .slot_o(slot), .clk8_o(clk8_o), .phi2_o(phi2_o),
        .pi_select_o(pi_select), .pi_strobe_o(pi_strobe),
        .video_select_o(video_select_o), .video_ram_strobe_o(video_ram_strobe_o),
        .video_rom_strobe_o(video_rom_strobe_o), .cpu_select_o(cpu_select),
        .cpu_read_o(cpu_read), .cpu_write_o(cpu_write)
    );

    pi_sync u_pi_sync (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i),
        .pi_select_i(pi_select), .pi_strobe_i(pi_strobe),
        .pi_pending_i(pi_pending_i), .pi_rw_b_i(pi_rw_b_i),
        .pi_read_o(pi_read), .pi_write_o(pi_write), .pi_done_o(pi_done_o),
        .state_o()                          // Observed only in simulation
    );

    pi_ctl_reg u_ctl (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i), .pi_write_i(pi_write),
        .pi_addr_i(pi_addr_i), .pi_data_i(pi_data_i),
        .cpu_res_b_o(cpu_res_b_o), .cpu_rdy_o(cpu_rdy_o)
    );

    address_decoder u_dec (
        .bus_addr_i(bus_addr_i), .cpu_be_i(cpu_be_o), .region_o(region),
        .pia1_cs_b_o(pia1_cs_b_o), .pia2_cs_b_o(pia2_cs_b_o), .via_cs_b_o(via_cs_b_o),
        .crtc_cs_b_o(crtc_cs_b_o), .io_oe_b_o(io_oe_b_o)
    );

    assign cpu_be_o = cpu_select && cpu_rdy_o;      // Halted CPU stays off the bus

    // RAM stays enabled outside the CPU slot for host and video
    assign ram_ce = (region != pet_mem_pkg::REGION_IO) || !cpu_select;
    assign ram_oe = pi_read || video_select_o || (cpu_read && cpu_be_o);
    assign ram_we = pi_write
                    || (cpu_write && cpu_be_o && (region != pet_mem_pkg::REGION_ROM));

    assign ram_ce_b_o = !ram_ce;
    assign ram_oe_b_o = !ram_oe;
    assign ram_we_b_o = !ram_we;

    // Host sees all of RAM, CPU sees video RAM mirrored across $8000-$8FFF
    assign ram_addr_hi_o = (slot == pet_bus_pkg::SLOT_PI)          ? pi_addr_i[11:10]
                         : (region == pet_mem_pkg::REGION_VRAM)    ? 2'b00
                         :                                          bus_addr_i[11:10];

endmodule

`default_nettype wire

// File: hw/pet_config.svh
// --------------------------------------------------------------------------
// Fixed PET bus timing: frame length and slot phase numbers
// Fixed register addresses in the I/O page
// --------------------------------------------------------------------------
`ifndef PET_CONFIG_SVH
`define PET_CONFIG_SVH

// One CPU cycle is 16 ticks of the 16 MHz master clock
`define PET_FRAME_LEN       16

// Host slot
`define PET_PI_FIRST        0
`define PET_PI_LAST         3
`define PET_PI_STROBE       2        // Host access lands here

// Video fetch slot
`define PET_VID_FIRST       4
`define PET_VID_LAST        7
`define PET_VID_RAM_STROBE  5        // Character code latched
`define PET_VID_ROM_STROBE  7        // Glyph row latched

// CPU slot runs to the end of the frame
`define PET_CPU_FIRST       8
`define PET_PHI2_FIRST      12       // phi2 high for phases 12..15

`define PET_CTL_ADDR        16'hE80F // CPU reset / ready register
`define PET_IO_PAGE         8'hE8    // PIA, VIA and CRTC live in $E8xx

`endif

// File: hw/pet_mem_pkg.sv
// --------------------------------------------------------------------------
// Memory map types: PET address regions
// and bit positions of the CPU control register
// --------------------------------------------------------------------------
`default_nettype none

package pet_mem_pkg;

    // Coarse PET memory map
    typedef enum logic [1:0] {
        REGION_RAM  = 2'd0,  // $0000-$7FFF
        REGION_VRAM = 2'd1,  // $8000-$8FFF, 1K/2K mirrored
        REGION_ROM  = 2'd2,  // $9000-$E7FF and $F000-$FFFF
        REGION_IO   = 2'd3   // $E800-$EFFF
    } mem_region_e;

    // Bits of the control register at $E80F
    typedef enum logic {
        CTL_RES_B = 1'b0,    // 0 = hold CPU in reset
        CTL_RDY   = 1'b1     // 1 = CPU may run
    } ctl_bit_e;

    // Both bits clear after reset, so the CPU
    // stays parked until the host has loaded ROMs

endpackage

`default_nettype wire

// File: hw/pi_ctl_reg.sv
// --------------------------------------------------------------------------
// CPU control register at $E80F, written by the host
// Drives the 6502 reset and ready lines
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "pet_config.svh"

module pi_ctl_reg (
    input  wire logic        clk16_i,
    input  wire logic        rst_n_i,
    input  wire logic        pi_write_i,     // One-cycle host write strobe
    input  wire logic [15:0] pi_addr_i,
    input  wire logic [7:0]  pi_data_i,
    output logic             cpu_res_b_o,
    output logic             cpu_rdy_o
);
    logic [1:0] ctl_q;                       // {rdy, res_b}

    // Cleared in reset: CPU held in reset and halted
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctl_q <= 2'b00;
        end else if (pi_write_i && (pi_addr_i == `PET_CTL_ADDR)) begin
            ctl_q <= pi_data_i[1:0];         // Upper data bits are ignored
        end
    end

    // Writes to any other address land in RAM only
    assign cpu_res_b_o = ctl_q[pet_mem_pkg::CTL_RES_B];
    assign cpu_rdy_o   = ctl_q[pet_mem_pkg::CTL_RDY];

endmodule

`default_nettype wire

// File: hw/pi_sync.sv
// --------------------------------------------------------------------------
// Host access synchronizer: pending/done level handshake
// Issues one read or write strobe per pending pulse, inside the host slot
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pi_sync (
    input  wire logic               clk16_i,
    input  wire logic               rst_n_i,
    input  wire logic               pi_select_i,    // Host slot active
    input  wire logic               pi_strobe_i,    // Strobe phase of host slot
    input  wire logic               pi_pending_i,   // Level from host
    input  wire logic               pi_rw_b_i,      // 1 = host read
    output logic                    pi_read_o,
    output logic                    pi_write_o,
    output logic                    pi_done_o,
    output pet_bus_pkg::pi_state_e  state_o
);
    logic grant;                        // Access happens this cycle

    // Only from IDLE, so a held pending never gets a second access
    assign grant = (state_o == pet_bus_pkg::PI_IDLE) && pi_pending_i
                   && pi_select_i && pi_strobe_i;

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_o <= pet_bus_pkg::PI_IDLE;
        end else begin
            case (state_o)
                pet_bus_pkg::PI_IDLE:   if (grant) state_o <= pet_bus_pkg::PI_ACCESS;
                pet_bus_pkg::PI_ACCESS: state_o <= pi_pending_i ? pet_bus_pkg::PI_DONE
                                                                : pet_bus_pkg::PI_IDLE;
                pet_bus_pkg::PI_DONE:   if (!pi_pending_i) state_o <= pet_bus_pkg::PI_IDLE;
                default:                state_o <= pet_bus_pkg::PI_IDLE;
            endcase
        end
    end

    assign pi_read_o  = grant &&  pi_rw_b_i;
    assign pi_write_o = grant && !pi_rw_b_i;
    assign pi_done_o  = (state_o != pet_bus_pkg::PI_IDLE);   // Rises the cycle after grant

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the PET bus testbench with Verilator and runs it
# A failing check ends the simulation through $fatal with a non-zero status
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns --top-module tb_pet_bus \
    -f flist.f -Mdir obj_dir -o sim_pet_bus

./obj_dir/sim_pet_bus

// File: tb/pet_bus_golden.mem
// Columns: test _ address _ data _ rw_b _ expected
// Test 3 {rdy,res_b}; test 5 {oe_b,ce_b,we_b,io_oe_b,crtc,via,pia2,pia1}; test 6 ram_addr_hi
3_E80F_01_0_01
3_E80E_03_0_01
3_E80F_FE_0_02
3_0F0F_03_0_02
3_E80F_00_1_02
3_E80F_03_0_03
5_E810_00_1_6E
5_E820_00_1_6D
5_E840_00_1_6B
5_E880_00_1_67
5_E84F_00_0_CB
5_E80F_00_1_6F
5_E8F0_00_1_60
5_E900_00_1_7F
5_F000_00_0_BF
5_C000_00_0_BF
5_1234_00_0_9F
5_8123_00_1_3F
6_8C00_00_1_00
6_8FFF_00_1_00
6_0C00_00_1_03
6_0800_00_1_02
6_7400_00_1_01
6_FC00_00_1_03
6_9C00_00_1_03

// File: tb/tb_pet_bus.sv
// --------------------------------------------------------------------------
// PET bus glue testbench: reset values, frame timing, host handshake,
// control register, memory map decode and RAM address steering
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "pet_config.svh"

module tb_pet_bus;
    localparam int MAX_VEC = 32;

    logic        clk, rst_n, bus_rw_b, pi_pending, pi_rw_b;
    logic [15:0] bus_addr, pi_addr;
    logic [7:0]  pi_data;
    logic        clk8, phi2, pi_done, cpu_res_b, cpu_rdy, cpu_be;
    logic        ram_ce_b, ram_oe_b, ram_we_b, io_oe_b;
    logic        pia1_cs_b, pia2_cs_b, via_cs_b, crtc_cs_b;
    logic        video_select, video_ram_strobe, video_rom_strobe;
    logic [1:0]  ram_addr_hi;
    logic [39:0] vec_mem [0:MAX_VEC-1];     // {test, addr, data, rw_b, expected}
    int          vec_count;
    int          out_phase;                 // Phase the registered outputs show
    int          we_falls;                  // RAM write enable pulses of any width
    bit          loaded;

    pet_bus_top dut (
        .clk16_i(clk), .rst_n_i(rst_n), .bus_rw_b_i(bus_rw_b), .pi_pending_i(pi_pending),
        .pi_rw_b_i(pi_rw_b), .bus_addr_i(bus_addr), .pi_addr_i(pi_addr), .pi_data_i(pi_data),
        .clk8_o(clk8), .phi2_o(phi2), .pi_done_o(pi_done), .cpu_res_b_o(cpu_res_b),
        .cpu_rdy_o(cpu_rdy), .cpu_be_o(cpu_be), .ram_ce_b_o(ram_ce_b), .ram_oe_b_o(ram_oe_b),
        .ram_we_b_o(ram_we_b), .pia1_cs_b_o(pia1_cs_b), .pia2_cs_b_o(pia2_cs_b),
        .via_cs_b_o(via_cs_b), .crtc_cs_b_o(crtc_cs_b), .io_oe_b_o(io_oe_b),
        .video_select_o(video_select), .video_ram_strobe_o(video_ram_strobe),
        .video_rom_strobe_o(video_rom_strobe), .ram_addr_hi_o(ram_addr_hi)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;             // 50 MHz stand-in for clk16
    end

    // Phase 0 appears after the first rising edge out of reset
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_phase <= `PET_FRAME_LEN - 1;
        else
            out_phase <= (out_phase + 1) % `PET_FRAME_LEN;
    end

    // A host write can start half way through a cycle
    always @(negedge ram_we_b)
        we_falls++;

    // Two frames per vector plus frames for reset, timing and random host traffic
    initial begin
        wait (loaded);
        repeat ((vec_count * 2 + 40) * `PET_FRAME_LEN) @(posedge clk);
        abort_run("Timeout: the tests did not finish in the expected time");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopped on first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_frames(input int frames);
        int f, c, vid_cnt, phi_cnt, ram_cnt, rom_cnt;
        for (f = 0; f < frames; f++) begin
            vid_cnt = 0;
            phi_cnt = 0;
            ram_cnt = 0;
            rom_cnt = 0;
            for (c = 0; c < `PET_FRAME_LEN; c++) begin
                @(negedge clk);
                check_value("video_select", 32'(c >= `PET_VID_FIRST && c <= `PET_VID_LAST),
                            32'(video_select));
                check_value("phi2", 32'(c >= `PET_PHI2_FIRST), 32'(phi2));
                check_value("video_ram_strobe", 32'(c == `PET_VID_RAM_STROBE),
                            32'(video_ram_strobe));
                check_value("video_rom_strobe", 32'(c == `PET_VID_ROM_STROBE),
                            32'(video_rom_strobe));
                check_value("clk8", c % 2, 32'(clk8));           // Toggles every cycle
                check_value("cpu_be parked", 0, 32'(cpu_be));     // CPU not ready yet
                vid_cnt += int'(video_select);
                phi_cnt += int'(phi2);
                ram_cnt += int'(video_ram_strobe);
                rom_cnt += int'(video_rom_strobe);
            end
            check_value("video_select cycles", 4, vid_cnt);
            check_value("phi2 cycles", 4, phi_cnt);
            check_value("video_ram_strobe pulses", 1, ram_cnt);
            check_value("video_rom_strobe pulses", 1, rom_cnt);
        end
    endtask

    // Pending is held across a second strobe phase to catch a repeated access
    task automatic host_access(input logic [15:0] addr, input logic [7:0] data,
                               input logic rw_b, input logic [1:0] exp_ctl);
        int c, lat, we_base;
        repeat (1 + $urandom % 8) @(negedge clk);           // Random host gap
        we_base    = we_falls;
        pi_addr    = addr;
        pi_data    = data;
        pi_rw_b    = rw_b;
        pi_pending = 1'b1;
        lat        = 0;
        for (c = 1; c <= 17 + `PET_FRAME_LEN; c++) begin
            @(negedge clk);
            if (pi_done && lat == 0) begin
                lat = c;
                check_value("res_b at done", 32'(exp_ctl[pet_mem_pkg::CTL_RES_B]),
                            32'(cpu_res_b));
                check_value("rdy at done", 32'(exp_ctl[pet_mem_pkg::CTL_RDY]), 32'(cpu_rdy));
                // Still the host slot, so the host address steers RAM
                check_value("host ram_addr_hi", 32'(addr[11:10]), 32'(ram_addr_hi));
            end
        end
        if (lat == 0 || lat > 17)
            abort_run("Host access did not see done within 17 cycles");
        check_value("host write enables", rw_b ? 0 : 1, we_falls - we_base);
        check_value("done held", 1, 32'(pi_done));
        pi_pending = 1'b0;
        @(negedge clk);
        check_value("done fall", 0, 32'(pi_done));
        check_value("host state", 32'(pet_bus_pkg::PI_IDLE), 32'(dut.u_pi_sync.state_o));
    endtask

    task automatic cpu_vector(input logic [39:0] v);
        string name;
        do begin
            @(negedge clk);
        end while (out_phase != `PET_PHI2_FIRST - 1);
        bus_addr = v[35:20];
        bus_rw_b = v[8];
        @(negedge clk);                                     // First cycle of phi2
        name = $sformatf("test%0d addr %h", v[39:36], v[35:20]);
        check_value({name, " cpu slot"}, 32'(pet_bus_pkg::SLOT_CPU), 32'(dut.u_seq.slot_o));
        check_value({name, " cpu_be"}, 1, 32'(cpu_be));    // Released CPU owns the bus
        if (v[39:36] == 4'd5) begin
            check_value({name, " selects"}, 32'(v[7:0]), 32'({ram_oe_b, ram_ce_b, ram_we_b,
                        io_oe_b, crtc_cs_b, via_cs_b, pia2_cs_b, pia1_cs_b}));
        end else begin
            check_value({name, " ram_addr_hi"}, 32'(v[1:0]), 32'(ram_addr_hi));
            if (v[35:32] == 4'h8)
                check_value({name, " region"}, 32'(pet_mem_pkg::REGION_VRAM), 32'(dut.region));
        end
        bus_rw_b = 1'b1;
    endtask

    initial begin
        int i;
        logic [39:0] v;
        rst_n      = 1'b0;
        bus_rw_b   = 1'b1;
        pi_pending = 1'b0;
        pi_rw_b    = 1'b1;
        bus_addr   = 16'h0000;
        pi_addr    = 16'h0000;
        pi_data    = 8'h00;
        loaded     = 1'b0;
        void'($urandom(32'h86216146));                      // Seeds the generator once
        for (i = 0; i < MAX_VEC; i++)
            vec_mem[i] = 40'(i);                            // Test field 0 ends the list
        $readmemh("tb/pet_bus_golden.mem", vec_mem);
        vec_count = 0;
        while (vec_count < MAX_VEC && vec_mem[vec_count][39:36] != 4'd0)
            vec_count++;
        if (vec_count == 0)
            abort_run("No golden vectors were loaded");
        loaded = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("reset outputs", 0, 32'({phi2, video_select, video_ram_strobe,
                        video_rom_strobe, pi_done, cpu_res_b, cpu_rdy}));
        end
        rst_n = 1'b1;
        check_frames(2);
        // Random RAM accesses, CPU stays parked
        repeat (4) host_access({1'b0, 15'($urandom)}, 8'($urandom), 1'($urandom), 2'b00);
        for (i = 0; i < vec_count; i++) begin
            v = vec_mem[i];
            if (v[39:36] == 4'd3)
                host_access(v[35:20], v[19:12], v[8], v[1:0]);
            else
                cpu_vector(v);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
